/* rtl/core_pkg.sv */
package core_pkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;

   // Main sequencer states
   typedef enum logic [2:0] {
      ST_RESET     = 3'd0,
      ST_FETCH     = 3'd1,
      ST_DECODE    = 3'd2,
      ST_EXEC      = 3'd3,
      ST_MEM       = 3'd4,
      ST_WRITEBACK = 3'd5,
      ST_TRAP      = 3'd6,
      ST_MRET      = 3'd7
   } state_e;

   // RV32 major opcode field, insn[6:0]
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_BRANCH = 7'b1100011,
      OPC_JAL    = 7'b1101111,
      OPC_SYSTEM = 7'b1110011
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      ALU_SUB    = 3'd1,
      ALU_AND    = 3'd2,
      ALU_OR     = 3'd3,
      ALU_XOR    = 3'd4,
      ALU_PASS_B = 3'd5
   } alu_op_e;

   // Fixed encodings
   localparam logic [XLEN-1:0] INSN_NOP  = 32'h0000_0013;
   localparam logic [XLEN-1:0] INSN_MRET = 32'h3020_0073;

   // mcause values
   localparam logic [XLEN-1:0] CAUSE_TIMER_IRQ   = 32'h8000_0007;
   localparam logic [XLEN-1:0] CAUSE_FETCH_FAULT = 32'h0000_0001;
   localparam logic [XLEN-1:0] CAUSE_LOAD_FAULT  = 32'h0000_0005;
   localparam logic [XLEN-1:0] CAUSE_STORE_FAULT = 32'h0000_0007;

endpackage

/* rtl/bus_watchdog.sv */
module bus_watchdog #(
   parameter logic [15:0] BUS_TIMEOUT = 16'd32
) (
   input  logic clk,
   input  logic reset,
   input  logic req_i,
   output logic timeout_o
);

   logic [15:0] wait_cnt;

   // Counts cycles of the open request, saturates at the limit
   always_ff @(posedge clk) begin
      if (reset || !req_i) begin
         wait_cnt <= '0;
      end else if (wait_cnt != BUS_TIMEOUT) begin
         wait_cnt <= wait_cnt + 16'd1;
      end
   end

   assign timeout_o = (wait_cnt == BUS_TIMEOUT);

endmodule

/* rtl/reg_file.sv */
module reg_file import core_pkg::*; (
   input  logic                  clk,
   input  logic                  we_i,
   input  logic [REG_ADDR_W-1:0] rs1_i,
   input  logic [REG_ADDR_W-1:0] rs2_i,
   input  logic [REG_ADDR_W-1:0] rd_i,
   input  logic [XLEN-1:0]       wdata_i,
   output logic [XLEN-1:0]       rdata1_o,
   output logic [XLEN-1:0]       rdata2_o
);

   logic [XLEN-1:0] regs [0:31];

   always_ff @(posedge clk) begin
      if (we_i && (rd_i != '0)) begin
         regs[rd_i] <= wdata_i;
      end
   end

   // x0 reads as zero
   assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
   assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* rtl/insn_decoder.sv */
module insn_decoder import core_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  load_i,
   input  logic [XLEN-1:0]       insn_i,
   output opcode_e               opcode_o,
   output logic [REG_ADDR_W-1:0] rs1_o,
   output logic [REG_ADDR_W-1:0] rs2_o,
   output logic [REG_ADDR_W-1:0] rd_o,
   output logic [XLEN-1:0]       imm_o,
   output alu_op_e               alu_op_o,
   output logic                  is_bne_o,
   output logic                  is_mret_o
);

   logic [XLEN-1:0] ir;
   logic [2:0]      funct3;

   always_ff @(posedge clk) begin
      if (reset) begin
         ir <= INSN_NOP;
      end else if (load_i) begin
         ir <= insn_i;
      end
   end

   assign opcode_o  = opcode_e'(ir[6:0]);
   assign rd_o      = ir[11:7];
   assign rs1_o     = ir[19:15];
   assign rs2_o     = ir[24:20];
   assign funct3    = ir[14:12];
   assign is_bne_o  = (funct3 == 3'b001);
   assign is_mret_o = (ir == INSN_MRET);

   always_comb begin
      imm_o    = {{20{ir[31]}}, ir[31:20]};
      alu_op_o = ALU_ADD;
      case (opcode_o)
         OPC_OP, OPC_OP_IMM: begin
            case (funct3)
               3'b000:  alu_op_o = (opcode_o == OPC_OP && ir[30]) ? ALU_SUB : ALU_ADD;
               3'b100:  alu_op_o = ALU_XOR;
               3'b110:  alu_op_o = ALU_OR;
               3'b111:  alu_op_o = ALU_AND;
               default: alu_op_o = ALU_ADD;
            endcase
         end
         OPC_LUI: begin
            imm_o    = {ir[31:12], 12'b0};
            alu_op_o = ALU_PASS_B;
         end
         OPC_STORE: imm_o = {{20{ir[31]}}, ir[31:25], ir[11:7]};
         OPC_BRANCH: begin
            imm_o    = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            alu_op_o = ALU_SUB;
         end
         OPC_JAL: imm_o = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
         default: ;
      endcase
   end

endmodule

/* rtl/trap_csr.sv */
module trap_csr import core_pkg::*; (
   input  logic            clk,
   input  logic            reset,
   input  logic            trap_take_i,
   input  logic            mret_take_i,
   input  logic [XLEN-1:0] cause_i,
   input  logic [XLEN-1:0] pc_i,
   output logic            mie_o,
   output logic            trap_o,
   output logic [XLEN-1:0] mepc_o,
   output logic [XLEN-1:0] mcause_o
);

   logic mie;
   logic mpie;

   // mstatus bits and the trap pulse
   always_ff @(posedge clk) begin
      if (reset) begin
         mie    <= 1'b1;
         mpie   <= 1'b0;
         trap_o <= 1'b0;
      end else begin
         trap_o <= trap_take_i;
         if (trap_take_i) begin
            mpie <= mie;
            mie  <= 1'b0;
         end else if (mret_take_i) begin
            mie  <= mpie;
            mpie <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (trap_take_i) begin
         mepc_o   <= pc_i;
         mcause_o <= cause_i;
      end
   end

   assign mie_o = mie;

endmodule

/* rtl/core_control.sv */
module core_control import core_pkg::*; (
   input  logic            clk,
   input  logic            reset,
   input  logic            bus_ack_i,
   input  logic            timer_irq_i,
   input  logic            timeout_i,
   input  logic            mie_i,
   input  logic            branch_taken_i,
   input  logic            is_mret_i,
   input  opcode_e         opcode_i,
   output logic            bus_cyc_o,
   output logic            bus_we_o,
   output logic            addr_sel_o,
   output logic            ir_load_o,
   output logic            pc_load_o,
   output logic            pc_src_o,
   output logic            reg_we_o,
   output logic            wb_sel_o,
   output logic            trap_take_o,
   output logic            mret_take_o,
   output logic [XLEN-1:0] trap_cause_o
);

   state_e state;
   state_e next_state;
   logic   is_store;
   logic   writes_rd;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_RESET;
      end else begin
         state <= next_state;
      end
   end

   assign is_store  = (opcode_i == OPC_STORE);
   assign writes_rd = (opcode_i == OPC_OP) || (opcode_i == OPC_OP_IMM) ||
                      (opcode_i == OPC_LUI) || (opcode_i == OPC_JAL);

   // ========================================================================
   // Bus request, dropped as soon as the watchdog fires
   // ========================================================================
   assign bus_cyc_o  = ((state == ST_FETCH) || (state == ST_MEM)) && !timeout_i;
   assign bus_we_o   = (state == ST_MEM) && is_store && !timeout_i;
   assign addr_sel_o = (state == ST_MEM);

   // ========================================================================
   // Sequencer
   // ========================================================================
   always_comb begin
      next_state   = state;
      ir_load_o    = 1'b0;
      pc_load_o    = 1'b0;
      pc_src_o     = 1'b0;
      reg_we_o     = 1'b0;
      wb_sel_o     = 1'b0;
      trap_take_o  = 1'b0;
      mret_take_o  = 1'b0;
      trap_cause_o = '0;
      case (state)
         ST_RESET: next_state = ST_FETCH;
         ST_FETCH: begin
            if (timeout_i) begin
               trap_take_o  = 1'b1;
               pc_load_o    = 1'b1;
               trap_cause_o = CAUSE_FETCH_FAULT;
               next_state   = ST_TRAP;
            end else if (bus_ack_i) begin
               ir_load_o  = 1'b1;
               next_state = ST_DECODE;
            end
         end
         ST_DECODE: begin
            // Pending interrupt discards the fetched word
            if (timer_irq_i && mie_i) begin
               trap_take_o  = 1'b1;
               pc_load_o    = 1'b1;
               trap_cause_o = CAUSE_TIMER_IRQ;
               next_state   = ST_TRAP;
            end else begin
               next_state = ST_EXEC;
            end
         end
         ST_EXEC: begin
            if ((opcode_i == OPC_LOAD) || is_store) begin
               next_state = ST_MEM;
            end else if ((opcode_i == OPC_SYSTEM) && is_mret_i) begin
               next_state = ST_MRET;
            end else begin
               next_state = ST_WRITEBACK;
            end
         end
         ST_MEM: begin
            wb_sel_o = 1'b1;
            if (timeout_i) begin
               trap_take_o  = 1'b1;
               pc_load_o    = 1'b1;
               trap_cause_o = is_store ? CAUSE_STORE_FAULT : CAUSE_LOAD_FAULT;
               next_state   = ST_TRAP;
            end else if (bus_ack_i) begin
               // Load data is only valid in the ack cycle
               reg_we_o   = !is_store;
               next_state = ST_WRITEBACK;
            end
         end
         ST_WRITEBACK: begin
            pc_load_o  = 1'b1;
            pc_src_o   = branch_taken_i;
            reg_we_o   = writes_rd;
            next_state = ST_FETCH;
         end
         ST_TRAP: next_state = ST_FETCH;
         ST_MRET: begin
            mret_take_o = 1'b1;
            pc_load_o   = 1'b1;
            next_state  = ST_FETCH;
         end
         default: next_state = ST_RESET;
      endcase
   end

endmodule

/* rtl/core_datapath.sv */
module core_datapath import core_pkg::*; #(
   parameter logic [31:0] VECTOR_RESET     = 32'h0000_0000,
   parameter logic [31:0] VECTOR_EXCEPTION = 32'h0000_0100
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  addr_sel_i,
   input  logic                  pc_load_i,
   input  logic                  pc_src_i,
   input  logic                  reg_we_i,
   input  logic                  wb_sel_i,
   input  logic                  is_bne_i,
   input  logic                  trap_take_i,
   input  logic                  mret_take_i,
   input  opcode_e               opcode_i,
   input  alu_op_e               alu_op_i,
   input  logic [REG_ADDR_W-1:0] rs1_i,
   input  logic [REG_ADDR_W-1:0] rs2_i,
   input  logic [REG_ADDR_W-1:0] rd_i,
   input  logic [XLEN-1:0]       imm_i,
   input  logic [XLEN-1:0]       mepc_i,
   input  logic [XLEN-1:0]       bus_dat_i,
   output logic [XLEN-1:0]       bus_adr_o,
   output logic [XLEN-1:0]       bus_dat_o,
   output logic [XLEN-1:0]       pc_o,
   output logic                  branch_taken_o
);

   logic [XLEN-1:0] pc;
   logic [XLEN-1:0] pc_plus4;
   logic [XLEN-1:0] next_pc;
   logic [XLEN-1:0] rdata1;
   logic [XLEN-1:0] rdata2;
   logic [XLEN-1:0] op_b;
   logic [XLEN-1:0] alu_res;
   logic [XLEN-1:0] wb_data;
   logic            regs_equal;

   reg_file u_reg_file (
      .clk      (clk),
      .we_i     (reg_we_i),
      .rs1_i    (rs1_i),
      .rs2_i    (rs2_i),
      .rd_i     (rd_i),
      .wdata_i  (wb_data),
      .rdata1_o (rdata1),
      .rdata2_o (rdata2)
   );

   // ========================================================================
   // ALU
   // ========================================================================
   assign op_b = (opcode_i == OPC_OP) ? rdata2 : imm_i;

   always_comb begin
      case (alu_op_i)
         ALU_SUB:    alu_res = rdata1 - op_b;
         ALU_AND:    alu_res = rdata1 & op_b;
         ALU_OR:     alu_res = rdata1 | op_b;
         ALU_XOR:    alu_res = rdata1 ^ op_b;
         ALU_PASS_B: alu_res = op_b;
         default:    alu_res = rdata1 + op_b;
      endcase
   end

   // BEQ/BNE compare, JAL always taken
   assign regs_equal     = (rdata1 == rdata2);
   assign branch_taken_o = (opcode_i == OPC_JAL) ||
                           ((opcode_i == OPC_BRANCH) && (regs_equal != is_bne_i));

   // ========================================================================
   // PC and next PC
   // ========================================================================
   assign pc_plus4 = pc + 32'd4;

   always_comb begin
      if (trap_take_i) begin
         next_pc = VECTOR_EXCEPTION;
      end else if (mret_take_i) begin
         next_pc = mepc_i;
      end else if (pc_src_i) begin
         next_pc = pc + imm_i;
      end else begin
         next_pc = pc_plus4;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= VECTOR_RESET;
      end else if (pc_load_i) begin
         pc <= next_pc;
      end
   end

   assign pc_o      = pc;
   assign bus_adr_o = addr_sel_i ? alu_res : pc;
   assign bus_dat_o = rdata2;

   // Link address for JAL, load data in MEM
   assign wb_data = (opcode_i == OPC_JAL) ? pc_plus4 :
                    wb_sel_i              ? bus_dat_i : alu_res;

endmodule

/* rtl/core_top.sv */
module core_top import core_pkg::*; #(
   parameter logic [31:0] VECTOR_RESET     = 32'h0000_0000,
   parameter logic [31:0] VECTOR_EXCEPTION = 32'h0000_0100,
   parameter logic [15:0] BUS_TIMEOUT      = 16'd32
) (
   input  logic            clk,
   input  logic            reset,
   input  logic [XLEN-1:0] bus_dat_i,
   input  logic            bus_ack_i,
   input  logic            timer_irq_i,
   output logic            bus_cyc_o,
   output logic            bus_we_o,
   output logic [XLEN-1:0] bus_adr_o,
   output logic [XLEN-1:0] bus_dat_o,
   output logic            trap_o,
   output logic [XLEN-1:0] trap_cause_o,
   output logic [XLEN-1:0] trap_epc_o
);

   logic                  timeout;
   logic                  mie;
   logic                  branch_taken;
   logic                  is_mret;
   logic                  is_bne;
   opcode_e               opcode;
   alu_op_e               alu_op;
   logic                  addr_sel;
   logic                  ir_load;
   logic                  pc_load;
   logic                  pc_src;
   logic                  reg_we;
   logic                  wb_sel;
   logic                  trap_take;
   logic                  mret_take;
   logic [XLEN-1:0]       cause;
   logic [REG_ADDR_W-1:0] rs1;
   logic [REG_ADDR_W-1:0] rs2;
   logic [REG_ADDR_W-1:0] rd;
   logic [XLEN-1:0]       imm;
   logic [XLEN-1:0]       pc;

   core_control u_control (
      .clk            (clk),
      .reset          (reset),
      .bus_ack_i      (bus_ack_i),
      .timer_irq_i    (timer_irq_i),
      .timeout_i      (timeout),
      .mie_i          (mie),
      .branch_taken_i (branch_taken),
      .is_mret_i      (is_mret),
      .opcode_i       (opcode),
      .bus_cyc_o      (bus_cyc_o),
      .bus_we_o       (bus_we_o),
      .addr_sel_o     (addr_sel),
      .ir_load_o      (ir_load),
      .pc_load_o      (pc_load),
      .pc_src_o       (pc_src),
      .reg_we_o       (reg_we),
      .wb_sel_o       (wb_sel),
      .trap_take_o    (trap_take),
      .mret_take_o    (mret_take),
      .trap_cause_o   (cause)
   );

   bus_watchdog #(
      .BUS_TIMEOUT (BUS_TIMEOUT)
   ) u_watchdog (
      .clk       (clk),
      .reset     (reset),
      .req_i     (bus_cyc_o),
      .timeout_o (timeout)
   );

   insn_decoder u_decoder (
      .clk       (clk),
      .reset     (reset),
      .load_i    (ir_load),
      .insn_i    (bus_dat_i),
      .opcode_o  (opcode),
      .rs1_o     (rs1),
      .rs2_o     (rs2),
      .rd_o      (rd),
      .imm_o     (imm),
      .alu_op_o  (alu_op),
      .is_bne_o  (is_bne),
      .is_mret_o (is_mret)
   );

   core_datapath #(
      .VECTOR_RESET     (VECTOR_RESET),
      .VECTOR_EXCEPTION (VECTOR_EXCEPTION)
   ) u_datapath (
      .clk            (clk),
      .reset          (reset),
      .addr_sel_i     (addr_sel),
      .pc_load_i      (pc_load),
      .pc_src_i       (pc_src),
      .reg_we_i       (reg_we),
      .wb_sel_i       (wb_sel),
      .is_bne_i       (is_bne),
      .trap_take_i    (trap_take),
      .mret_take_i    (mret_take),
      .opcode_i       (opcode),
      .alu_op_i       (alu_op),
      .rs1_i          (rs1),
      .rs2_i          (rs2),
      .rd_i           (rd),
      .imm_i          (imm),
      .mepc_i         (trap_epc_o),
      .bus_dat_i      (bus_dat_i),
      .bus_adr_o      (bus_adr_o),
      .bus_dat_o      (bus_dat_o),
      .pc_o           (pc),
      .branch_taken_o (branch_taken)
   );

   trap_csr u_trap_csr (
      .clk         (clk),
      .reset       (reset),
      .trap_take_i (trap_take),
      .mret_take_i (mret_take),
      .cause_i     (cause),
      .pc_i        (pc),
      .mie_o       (mie),
      .trap_o      (trap_o),
      .mepc_o      (trap_epc_o),
      .mcause_o    (trap_cause_o)
   );

endmodule

/* verification/clk_gen.sv */
module clk_gen #(
   parameter int PERIOD = 4
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
   end

   always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

/* verification/core_checker.sv */
module core_checker (
   input logic        clk,
   input logic        reset,
   input logic        bus_cyc_i,
   input logic        bus_we_i,
   input logic        bus_ack_i,
   input logic [31:0] bus_adr_i,
   input logic        trap_i
);

   int fail_count = 0;

   // Request held open without ack keeps address and direction
   a_bus_stable: assert property (@(posedge clk) disable iff (reset)
      (bus_cyc_i && !bus_ack_i) ##1 bus_cyc_i |-> $stable(bus_adr_i) && $stable(bus_we_i))
      else begin
         fail_count++;
         $error("bus address or write enable changed during an open request");
      end

   a_trap_pulse: assert property (@(posedge clk) disable iff (reset)
      trap_i |=> !trap_i)
      else begin
         fail_count++;
         $error("trap_o high for more than one cycle");
      end

   // Request stays low through reset and the cycle after it
   a_reset_idle: assert property (@(posedge clk) reset |=> !bus_cyc_i)
      else begin
         fail_count++;
         $error("bus_cyc_o high during or right after reset");
      end

endmodule

bind core_top core_checker u_checker (
   .clk       (clk),
   .reset     (reset),
   .bus_cyc_i (bus_cyc_o),
   .bus_we_i  (bus_we_o),
   .bus_ack_i (bus_ack_i),
   .bus_adr_i (bus_adr_o),
   .trap_i    (trap_o)
);

/* verification/tb_core.sv */
module tb_core;

   localparam logic [31:0] VECTOR_RESET     = 32'h0000_0000;
   localparam logic [31:0] VECTOR_EXCEPTION = 32'h0000_0100;
   localparam logic [31:0] IRQ_TRIGGER_ADDR = 32'h0000_07F0;
   localparam logic [31:0] IRQ_CLEAR_ADDR   = 32'h0000_07F4;
   localparam logic [31:0] NOACK_ADDR       = 32'h0000_07F8;
   localparam int          MAX_RECORDS      = 64;

   logic        clk;
   logic        reset;
   logic [31:0] bus_dat_i;
   logic        bus_ack_i;
   logic        timer_irq_i;
   logic        bus_cyc_o;
   logic        bus_we_o;
   logic [31:0] bus_adr_o;
   logic [31:0] bus_dat_o;
   logic        trap_o;
   logic [31:0] trap_cause_o;
   logic [31:0] trap_epc_o;

   logic [31:0] vec [0:3*MAX_RECORDS-1];
   logic [31:0] mem [0:511];
   logic [31:0] exp_st_adr [$];
   logic [31:0] exp_st_dat [$];
   logic [31:0] exp_cause [$];
   logic [31:0] exp_epc [$];
   int          n_records;
   int          stores_seen;
   int          traps_seen;
   int          err_value;
   int          err_other;
   logic [31:0] seed;
   logic        active;
   logic        noack;
   logic        noack_used;
   logic        first_seen;
   int          delay;

   clk_gen #(.PERIOD(4)) u_clk_gen (.clk_o(clk));

   core_top #(
      .VECTOR_RESET     (VECTOR_RESET),
      .VECTOR_EXCEPTION (VECTOR_EXCEPTION),
      .BUS_TIMEOUT      (16'd32)
   ) uut (
      .clk          (clk),
      .reset        (reset),
      .bus_dat_i    (bus_dat_i),
      .bus_ack_i    (bus_ack_i),
      .timer_irq_i  (timer_irq_i),
      .bus_cyc_o    (bus_cyc_o),
      .bus_we_o     (bus_we_o),
      .bus_adr_o    (bus_adr_o),
      .bus_dat_o    (bus_dat_o),
      .trap_o       (trap_o),
      .trap_cause_o (trap_cause_o),
      .trap_epc_o   (trap_epc_o)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic compare_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
         err_value++;
      end
   endtask

   task automatic check_bus_idle();
      compare_word("bus_cyc_o", {31'b0, bus_cyc_o}, 32'd0);
      compare_word("trap_o", {31'b0, trap_o}, 32'd0);
   endtask

   // ========================================================================
   // Vector file: kind 1 memory word, 2 expected store, 3 expected trap
   // ========================================================================
   task automatic load_vectors();
      int i;
      for (i = 0; i < 512; i++) begin
         mem[i] = 32'hA5C3_0000 ^ (i << 2);
      end
      for (i = 0; i < 3 * MAX_RECORDS; i++) begin
         vec[i] = '0;
      end
      $readmemh("verification/core_vectors.txt", vec);
      n_records = 0;
      while (n_records < MAX_RECORDS && vec[3*n_records] != 0) begin
         case (vec[3*n_records])
            32'd1: mem[vec[3*n_records+1][10:2]] = vec[3*n_records+2];
            32'd2: begin
               exp_st_adr.push_back(vec[3*n_records+1]);
               exp_st_dat.push_back(vec[3*n_records+2]);
            end
            default: begin
               exp_cause.push_back(vec[3*n_records+1]);
               exp_epc.push_back(vec[3*n_records+2]);
            end
         endcase
         n_records++;
      end
   endtask

   task automatic record_store();
      if (stores_seen >= exp_st_adr.size()) begin
         $display("Unexpected extra store to %h at time %0t", bus_adr_o, $time);
         err_other++;
      end else begin
         compare_word("bus_adr_o", bus_adr_o, exp_st_adr[stores_seen]);
         compare_word("bus_dat_o", bus_dat_o, exp_st_dat[stores_seen]);
      end
      stores_seen++;
   endtask

   // ========================================================================
   // Memory model with random ack delay
   // ========================================================================
   always @(posedge clk) begin
      bus_ack_i <= 1'b0;
      if (reset || !bus_cyc_o) begin
         active = 1'b0;
      end else if (!bus_ack_i) begin
         if (!active) begin
            active = 1'b1;
            seed   = lcg_next(seed);
            delay  = seed[17:16];
            noack  = (bus_adr_o == NOACK_ADDR) && !noack_used;
            if (noack) begin
               noack_used = 1'b1;
            end
            if (!first_seen) begin
               first_seen = 1'b1;
               compare_word("bus_adr_o", bus_adr_o, VECTOR_RESET);
            end
         end
         if (!noack) begin
            if (delay == 0) begin
               active = 1'b0;
               bus_ack_i <= 1'b1;
               if (bus_we_o) begin
                  mem[bus_adr_o[10:2]] = bus_dat_o;
                  record_store();
                  if (bus_adr_o == IRQ_TRIGGER_ADDR) begin
                     timer_irq_i <= 1'b1;
                  end
                  if (bus_adr_o == IRQ_CLEAR_ADDR) begin
                     timer_irq_i <= 1'b0;
                  end
               end else begin
                  bus_dat_i <= mem[bus_adr_o[10:2]];
               end
            end else begin
               delay--;
            end
         end
      end
   end

   // Trap outputs are registered together with trap_o
   always @(posedge clk) begin
      if (!reset && trap_o) begin
         if (traps_seen >= exp_cause.size()) begin
            $display("Unexpected extra trap at time %0t", $time);
            err_other++;
         end else begin
            compare_word("trap_cause_o", trap_cause_o, exp_cause[traps_seen]);
            compare_word("trap_epc_o", trap_epc_o, exp_epc[traps_seen]);
         end
         traps_seen++;
      end
   end

   initial begin
      reset       = 1'b1;
      bus_dat_i   = '0;
      bus_ack_i   = 1'b0;
      timer_irq_i = 1'b0;
      seed        = 32'h26d4;
      active      = 1'b0;
      noack       = 1'b0;
      noack_used  = 1'b0;
      first_seen  = 1'b0;
      delay       = 0;
      stores_seen = 0;
      traps_seen  = 0;
      err_value   = 0;
      err_other   = 0;
      load_vectors();
      // Second reset cycle, then the cycle after reset falls
      @(posedge clk);
      @(negedge clk);
      check_bus_idle();
      @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_bus_idle();
      wait (stores_seen >= exp_st_adr.size() && traps_seen >= exp_cause.size());
      repeat (40) @(posedge clk);
      if (stores_seen != exp_st_adr.size() || traps_seen != exp_cause.size()) begin
         $display("Store or trap count differs from the vector file");
         err_other++;
      end
      $display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
               err_value, err_other, uut.u_checker.fail_count);
      if (err_value == 0 && err_other == 0 && uut.u_checker.fail_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Hang guard, sized from the vector count
   initial begin
      #1;
      repeat (n_records * 200) @(posedge clk);
      $display("Run hung: %0d of %0d stores, %0d of %0d traps seen", stores_seen,
               exp_st_adr.size(), traps_seen, exp_cause.size());
      $display("TEST FAILED");
      $finish;
   end

endmodule

/* verification/core_vectors.txt */
// kind addr/cause data/epc: 1 memory word, 2 expected store, 3 expected trap
// program at 0, handler at 100, load data at 7F8
1 00000000 00500093 1 00000004 00C00113 1 00000008 002081B3 1 0000000C 20302023
1 00000010 40110233 1 00000014 0041C2B3 1 00000018 12345337 1 0000001C 005363B3
1 00000020 20702223 1 00000024 0043F433 1 00000028 20402483 1 0000002C 20902423
1 00000030 00108463 1 00000034 20002623 1 00000038 00441463 1 0000003C 20002623
1 00000040 0080056F 1 00000044 20002623 1 00000048 20A02623 1 0000004C 7E802823
1 00000050 03300593 1 00000054 20B02823 1 00000058 7F802603 1 0000005C 20C02A23
1 00000060 0000006F 1 00000100 07700F93 1 00000104 7FF02A23 1 00000108 30200073
1 000007F8 CAFEF00D
2 00000200 00000011 2 00000204 12345016 2 00000208 12345016 2 0000020C 00000044
2 000007F0 00000006 2 000007F4 00000077 2 00000210 00000033 2 000007F4 00000077
2 00000214 CAFEF00D
3 80000007 00000050 3 00000005 00000058
0 00000000 00000000

/* sim.f */
rtl/core_pkg.sv
rtl/bus_watchdog.sv
rtl/reg_file.sv
rtl/insn_decoder.sv
rtl/trap_csr.sv
rtl/core_control.sv
rtl/core_datapath.sv
rtl/core_top.sv
verification/clk_gen.sv
verification/core_checker.sv
verification/tb_core.sv

/* Bender.yml */
package:
  name: rv32_multicycle_core

sources:
  - rtl/core_pkg.sv
  - rtl/bus_watchdog.sv
  - rtl/reg_file.sv
  - rtl/insn_decoder.sv
  - rtl/trap_csr.sv
  - rtl/core_control.sv
  - rtl/core_datapath.sv
  - rtl/core_top.sv
  - target: test
    files:
      - verification/clk_gen.sv
      - verification/core_checker.sv
      - verification/tb_core.sv
